//--- design/bpfcap_pkg.sv
/* word, address and burst types, register map and controller states
   shared by the capture engine */
package bpfcap_pkg;

    typedef logic [31:0] word_t;     // data word on a bus or in a register
    typedef logic [31:0] addr_t;     // byte address into memory
    typedef logic [15:0] burst_t;    // avalon burst count
    typedef logic [2:0]  reg_addr_t; // host register index

    // host register map
    localparam reg_addr_t REG_STATUS     = 3'd0; // read only
    localparam reg_addr_t REG_CONTROL    = 3'd1; // bit 0 enables the header
    localparam reg_addr_t REG_COMMAND    = 3'd2;
    localparam reg_addr_t REG_PKT_BEGIN  = 3'd3;
    localparam reg_addr_t REG_PKT_END    = 3'd4;
    localparam reg_addr_t REG_BUF_START  = 3'd5;
    localparam reg_addr_t REG_BUF_SIZE   = 3'd6; // in bytes
    localparam reg_addr_t REG_LAST_WRITE = 3'd7; // read only

    // capture sequencing states
    typedef enum logic [1:0] {
        IDLE   = 2'd0,
        RUN    = 2'd1,
        FINISH = 2'd2,
        DONE   = 2'd3
    } ctrl_state_t;

endpackage : bpfcap_pkg

//--- design/capture_fifo_if.sv
`timescale 1ns/1ns
/* FIFO signal bundle between the read master, the write master and the FIFO */
interface capture_fifo_if import bpfcap_pkg::*; #(
    parameter int FIFO_DEPTH = 256
);
    word_t                       data;         // word pushed by the read master
    logic                        wr_to_fifo;
    logic                        almost_full;
    logic                        rd_from_fifo; // pop, next word shows on q a cycle later
    word_t                       q;
    logic                        empty;
    logic [$clog2(FIFO_DEPTH):0] usedw;

    modport producer (output data, output wr_to_fifo, input almost_full);
    modport consumer (output rd_from_fifo, input q, input empty, input usedw);
    modport store (input data, input wr_to_fifo, input rd_from_fifo,
                   output q, output empty, output usedw, output almost_full);

endinterface : capture_fifo_if

//--- design/register_bank.sv
`timescale 1ns/1ns
/* host register bank: configuration registers, status word, registered readback */
module register_bank import bpfcap_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  reg_addr_t   address,
    input  logic        read,
    input  logic        write,
    input  word_t       writedata,
    output word_t       readdata,
    input  ctrl_state_t state,
    input  logic        busy,
    input  logic        done,
    input  logic        capt_buf_wrap,
    input  addr_t       last_write_addr,
    output word_t       out_control,
    output addr_t       out_pkt_begin,
    output addr_t       out_pkt_end,
    output addr_t       out_capt_buf_start,
    output word_t       out_capt_buf_size
);
    word_t status;

    assign status = {27'd0, capt_buf_wrap, done, busy, state};

    // command writes are decoded in the top, nothing stored here
    always_ff @(posedge clk) begin
        if (!reset) begin
            out_control        <= '0;
            out_pkt_begin      <= '0;
            out_pkt_end        <= '0;
            out_capt_buf_start <= '0;
            out_capt_buf_size  <= '0;
        end else if (write) begin
            case (address)
                REG_CONTROL:   out_control        <= writedata;
                REG_PKT_BEGIN: out_pkt_begin      <= writedata;
                REG_PKT_END:   out_pkt_end        <= writedata;
                REG_BUF_START: out_capt_buf_start <= writedata;
                REG_BUF_SIZE:  out_capt_buf_size  <= writedata;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            readdata <= '0;
        end else if (read) begin
            case (address)
                REG_STATUS:     readdata <= status;
                REG_CONTROL:    readdata <= out_control;
                REG_PKT_BEGIN:  readdata <= out_pkt_begin;
                REG_PKT_END:    readdata <= out_pkt_end;
                REG_BUF_START:  readdata <= out_capt_buf_start;
                REG_BUF_SIZE:   readdata <= out_capt_buf_size;
                REG_LAST_WRITE: readdata <= last_write_addr;
                default:        readdata <= '0; // command reads as zero
            endcase
        end
    end

endmodule : register_bank

//--- design/pkt_ctrl.sv
`timescale 1ns/1ns
/* capture sequencing FSM, starts both masters and waits for them to go idle */
module pkt_ctrl import bpfcap_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        new_request,
    input  logic        rd_ctrl_rdy,
    input  logic        wr_ctrl_rdy,
    output logic        rd_ctrl,
    output logic        wr_ctrl,
    output logic        busy,
    output logic        done,
    output ctrl_state_t state_out
);
    assign busy = (state_out == RUN) || (state_out == FINISH);
    assign done = (state_out == DONE);

    always_ff @(posedge clk) begin
        if (!reset) begin
            state_out <= IDLE;
            rd_ctrl   <= 1'b0;
            wr_ctrl   <= 1'b0;
        end else begin
            rd_ctrl <= 1'b0; // start strobes last one cycle
            wr_ctrl <= 1'b0;
            case (state_out)
                IDLE, DONE: begin
                    if (new_request) begin
                        state_out <= RUN;
                        rd_ctrl   <= 1'b1;
                        wr_ctrl   <= 1'b1;
                    end
                end
                // masters still report ready while the start strobe is high
                RUN:    if (rd_ctrl_rdy && wr_ctrl_rdy && !rd_ctrl) state_out <= FINISH;
                FINISH: state_out <= DONE;
                default: state_out <= IDLE;
            endcase
        end
    end

endmodule : pkt_ctrl

//--- design/rd_ctrl.sv
`timescale 1ns/1ns
/* avalon burst read master, walks the packet and pushes its words into the FIFO */
module rd_ctrl import bpfcap_pkg::*; #(
    parameter int BURST_SIZE_WORDS = 4
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             rd_ctrl,
    input  addr_t            pkt_begin,
    input  addr_t            pkt_end,
    capture_fifo_if.producer fifo,
    output logic             rd_ctrl_rdy,
    output addr_t            address,
    input  word_t            readdata,
    output logic             read,
    output burst_t           burstcount,
    input  logic             readdatavalid,
    input  logic             waitrequest
);
    typedef enum logic [1:0] {RD_IDLE, RD_ISSUE, RD_WAIT, RD_DATA} rd_state_t;

    rd_state_t state;
    addr_t     next_addr;  // start of the next burst
    addr_t     words_left; // words not yet requested
    burst_t    beats_left; // words still due in the current burst
    burst_t    next_burst;

    // last burst of the packet may be short
    assign next_burst = (words_left < addr_t'(BURST_SIZE_WORDS)) ? burst_t'(words_left)
                                                                : burst_t'(BURST_SIZE_WORDS);
    assign rd_ctrl_rdy = (state == RD_IDLE);

    always_ff @(posedge clk) begin
        if (!reset) begin
            state      <= RD_IDLE;
            read       <= 1'b0;
            address    <= '0;
            burstcount <= '0;
            next_addr  <= '0;
            words_left <= '0;
            beats_left <= '0;
        end else begin
            case (state)
                RD_IDLE: begin
                    if (rd_ctrl) begin
                        next_addr  <= pkt_begin;
                        words_left <= (pkt_end - pkt_begin) >> 2;
                        state      <= RD_ISSUE;
                    end
                end
                RD_ISSUE: begin
                    if (words_left == '0) begin
                        state <= RD_IDLE;
                    end else if (!fifo.almost_full) begin // room for a whole burst
                        read       <= 1'b1;
                        address    <= next_addr;
                        burstcount <= next_burst;
                        state      <= RD_WAIT;
                    end
                end
                RD_WAIT: begin
                    if (!waitrequest) begin // request accepted
                        read       <= 1'b0;
                        beats_left <= burstcount;
                        next_addr  <= next_addr + (addr_t'(burstcount) << 2);
                        words_left <= words_left - addr_t'(burstcount);
                        state      <= RD_DATA;
                    end
                end
                RD_DATA: begin
                    if (readdatavalid) begin
                        beats_left <= beats_left - burst_t'(1);
                        if (beats_left == burst_t'(1)) state <= RD_ISSUE;
                    end
                end
                default: state <= RD_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!reset) fifo.wr_to_fifo <= 1'b0;
        else        fifo.wr_to_fifo <= readdatavalid && (state == RD_DATA);
    end

    always_ff @(posedge clk) fifo.data <= readdata; // registered into the FIFO

endmodule : rd_ctrl

//--- design/wr_ctrl.sv
`timescale 1ns/1ns
/* avalon burst write master, writes an optional length/timestamp header and the
   packet words from the FIFO into the ring-shaped capture buffer */
module wr_ctrl import bpfcap_pkg::*; #(
    parameter int BURST_SIZE_WORDS = 4,
    parameter int FIFO_DEPTH       = 256
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             wr_ctrl,
    input  word_t            control,
    input  addr_t            pkt_begin,
    input  addr_t            pkt_end,
    input  addr_t            capt_buf_start,
    input  word_t            capt_buf_size,
    input  word_t            nanoseconds,
    capture_fifo_if.consumer fifo,
    output logic             wr_ctrl_rdy,
    output addr_t            last_write_addr,
    output logic             capt_buf_wrap,
    output addr_t            address,
    output word_t            writedata,
    output logic             write,
    output burst_t           burstcount,
    input  logic             waitrequest
);
    localparam int USEDW_W = $clog2(FIFO_DEPTH) + 1;

    typedef enum logic [2:0] {WR_IDLE, WR_SETUP, WR_HDR, WR_ISSUE, WR_DATA} wr_state_t;

    wr_state_t state;
    addr_t     wr_ptr;     // ring write pointer, kept across captures
    addr_t     cur_addr;
    addr_t     pkt_len;    // bytes
    addr_t     words_left;
    word_t     stamp;
    logic      hdr_en;
    logic      hdr_beat;   // 0 length word, 1 timestamp word
    burst_t    loads_left; // beats of the burst not yet taken from the FIFO
    burst_t    next_burst;
    addr_t     buf_end;
    addr_t     rec_len;
    addr_t     base;
    logic      wrap_needed;
    logic      beat_done;
    logic      load;

    assign buf_end     = capt_buf_start + capt_buf_size;
    assign rec_len     = pkt_len + (hdr_en ? 32'd8 : 32'd0);
    // pointer outside the buffer restarts at its start
    assign base        = ((wr_ptr >= capt_buf_start) && (wr_ptr < buf_end)) ? wr_ptr
                                                                            : capt_buf_start;
    assign wrap_needed = (base + rec_len) > buf_end;
    assign next_burst  = (words_left < addr_t'(BURST_SIZE_WORDS)) ? burst_t'(words_left)
                                                                 : burst_t'(BURST_SIZE_WORDS);
    assign beat_done   = write && !waitrequest;
    assign load        = (state == WR_DATA) && (loads_left != '0) && !fifo.empty
                         && (!write || beat_done);
    assign fifo.rd_from_fifo = load;
    assign wr_ctrl_rdy = (state == WR_IDLE);

    always_ff @(posedge clk) begin
        if (!reset) begin
            state           <= WR_IDLE;
            write           <= 1'b0;
            capt_buf_wrap   <= 1'b0;
            last_write_addr <= '0;
            wr_ptr          <= '0;
            hdr_beat        <= 1'b0;
            loads_left      <= '0;
        end else begin
            case (state)
                WR_IDLE: begin
                    if (wr_ctrl) begin
                        pkt_len       <= pkt_end - pkt_begin;
                        hdr_en        <= control[0];
                        stamp         <= nanoseconds; // time of the capture start
                        capt_buf_wrap <= 1'b0;
                        state         <= WR_SETUP;
                    end
                end
                WR_SETUP: begin
                    words_left    <= pkt_len >> 2;
                    cur_addr      <= wrap_needed ? capt_buf_start : base;
                    address       <= wrap_needed ? capt_buf_start : base;
                    capt_buf_wrap <= wrap_needed;
                    if (hdr_en) begin
                        burstcount <= burst_t'(2);
                        writedata  <= pkt_len;
                        hdr_beat   <= 1'b0;
                        write      <= 1'b1;
                        state      <= WR_HDR;
                    end else begin
                        state <= WR_ISSUE;
                    end
                end
                WR_HDR: begin
                    if (!waitrequest) begin
                        if (!hdr_beat) begin
                            writedata <= stamp;
                            hdr_beat  <= 1'b1;
                        end else begin
                            write    <= 1'b0;
                            cur_addr <= cur_addr + 32'd8;
                            state    <= WR_ISSUE;
                        end
                    end
                end
                WR_ISSUE: begin
                    if (words_left == '0) begin // record complete
                        last_write_addr <= cur_addr;
                        wr_ptr          <= cur_addr;
                        state           <= WR_IDLE;
                    end else if (fifo.usedw >= USEDW_W'(next_burst)) begin
                        address    <= cur_addr;
                        burstcount <= next_burst;
                        loads_left <= next_burst;
                        state      <= WR_DATA;
                    end
                end
                WR_DATA: begin
                    if (load) begin
                        writedata  <= fifo.q;
                        write      <= 1'b1;
                        loads_left <= loads_left - burst_t'(1);
                    end else if (beat_done) begin
                        write <= 1'b0; // FIFO ran empty or burst over
                        if (loads_left == '0) begin
                            cur_addr   <= cur_addr + (addr_t'(burstcount) << 2);
                            words_left <= words_left - addr_t'(burstcount);
                            state      <= WR_ISSUE;
                        end
                    end
                end
                default: state <= WR_IDLE;
            endcase
        end
    end

endmodule : wr_ctrl

//--- design/capture_fifo.sv
`timescale 1ns/1ns
/* circular FIFO with show-ahead output, used-word count and almost-full flag */
module capture_fifo import bpfcap_pkg::*; #(
    parameter int FIFO_DEPTH       = 256,
    parameter int BURST_SIZE_WORDS = 4
) (
    input  logic          clk,
    input  logic          reset,
    capture_fifo_if.store fifo
);
    localparam int PTR_W    = $clog2(FIFO_DEPTH);
    localparam int AF_LEVEL = FIFO_DEPTH - 2 * BURST_SIZE_WORDS; // two bursts of headroom

    word_t            mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             pop;

    assign pop              = fifo.rd_from_fifo && (count != '0);
    assign fifo.q           = mem[rd_ptr];
    assign fifo.empty       = (count == '0);
    assign fifo.usedw       = count;
    assign fifo.almost_full = count >= (PTR_W + 1)'(AF_LEVEL);

    always_ff @(posedge clk) begin
        if (fifo.wr_to_fifo) mem[wr_ptr] <= fifo.data;
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (fifo.wr_to_fifo) wr_ptr <= wr_ptr + 1'b1;
            if (pop)             rd_ptr <= rd_ptr + 1'b1;
            case ({fifo.wr_to_fifo, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ; // push and pop together leave the count alone
            endcase
        end
    end

endmodule : capture_fifo

//--- design/timestamp.sv
`timescale 1ns/1ns
/* free-running nanosecond and seconds counter */
module timestamp import bpfcap_pkg::*; #(
    parameter int FREQ = 50 // clock in MHz
) (
    input  logic  clk,
    input  logic  reset,
    output word_t nanoseconds
);
    localparam word_t NS_STEP    = word_t'(1000 / FREQ);
    localparam word_t NS_PER_SEC = 32'd1_000_000_000;

    word_t seconds; // internal only

    always_ff @(posedge clk) begin
        if (!reset) begin
            nanoseconds <= '0;
            seconds     <= '0;
        end else if (nanoseconds + NS_STEP >= NS_PER_SEC) begin
            nanoseconds <= nanoseconds + NS_STEP - NS_PER_SEC;
            seconds     <= seconds + 32'd1;
        end else begin
            nanoseconds <= nanoseconds + NS_STEP;
        end
    end

endmodule : timestamp

//--- design/bpfcap_top.sv
`timescale 1ns/1ns
/* packet capture engine top: command decode and block wiring */
module bpfcap_top import bpfcap_pkg::*; #(
    parameter int BURST_SIZE_WORDS = 4,
    parameter int FIFO_DEPTH       = 256,
    parameter int FREQ             = 50 // MHz
) (
    input  logic      clk,
    input  logic      reset,
    // host register port
    input  reg_addr_t avs_s0_address,
    input  word_t     avs_s0_writedata,
    input  logic      avs_s0_write,
    input  logic      avs_s0_read,
    output word_t     avs_s0_readdata,
    // read master
    output addr_t     avs_m0_address,
    input  word_t     avs_m0_readdata,
    output logic      avs_m0_read,
    output burst_t    avs_m0_burstcount,
    input  logic      avs_m0_readdatavalid,
    input  logic      avs_m0_waitrequest,
    // write master
    output addr_t     avs_m1_address,
    output word_t     avs_m1_writedata,
    output logic      avs_m1_write,
    output burst_t    avs_m1_burstcount,
    input  logic      avs_m1_waitrequest
);
    ctrl_state_t state;
    logic        new_request;
    logic        rd_start;
    logic        wr_start;
    logic        rd_ctrl_rdy;
    logic        wr_ctrl_rdy;
    logic        busy;
    logic        done;
    logic        capt_buf_wrap;
    word_t       out_control;
    addr_t       out_pkt_begin;
    addr_t       out_pkt_end;
    addr_t       out_capt_buf_start;
    word_t       out_capt_buf_size;
    addr_t       last_write_addr;
    word_t       nanoseconds;

    capture_fifo_if #(.FIFO_DEPTH(FIFO_DEPTH)) fifo_bus ();

    register_bank regs (
        .clk, .reset,
        .address(avs_s0_address), .read(avs_s0_read), .write(avs_s0_write),
        .writedata(avs_s0_writedata), .readdata(avs_s0_readdata),
        .state, .busy, .done, .capt_buf_wrap, .last_write_addr,
        .out_control, .out_pkt_begin, .out_pkt_end, .out_capt_buf_start, .out_capt_buf_size
    );

    pkt_ctrl packet_control (
        .clk, .reset, .new_request, .rd_ctrl_rdy, .wr_ctrl_rdy,
        .rd_ctrl(rd_start), .wr_ctrl(wr_start), .busy, .done, .state_out(state)
    );

    rd_ctrl #(.BURST_SIZE_WORDS(BURST_SIZE_WORDS)) read_control (
        .clk, .reset, .rd_ctrl(rd_start),
        .pkt_begin(out_pkt_begin), .pkt_end(out_pkt_end),
        .fifo(fifo_bus.producer), .rd_ctrl_rdy,
        .address(avs_m0_address), .readdata(avs_m0_readdata), .read(avs_m0_read),
        .burstcount(avs_m0_burstcount), .readdatavalid(avs_m0_readdatavalid),
        .waitrequest(avs_m0_waitrequest)
    );

    wr_ctrl #(.BURST_SIZE_WORDS(BURST_SIZE_WORDS), .FIFO_DEPTH(FIFO_DEPTH)) write_control (
        .clk, .reset, .wr_ctrl(wr_start), .control(out_control),
        .pkt_begin(out_pkt_begin), .pkt_end(out_pkt_end),
        .capt_buf_start(out_capt_buf_start), .capt_buf_size(out_capt_buf_size),
        .nanoseconds, .fifo(fifo_bus.consumer),
        .wr_ctrl_rdy, .last_write_addr, .capt_buf_wrap,
        .address(avs_m1_address), .writedata(avs_m1_writedata), .write(avs_m1_write),
        .burstcount(avs_m1_burstcount), .waitrequest(avs_m1_waitrequest)
    );

    capture_fifo #(.FIFO_DEPTH(FIFO_DEPTH), .BURST_SIZE_WORDS(BURST_SIZE_WORDS)) fifo_i (
        .clk, .reset, .fifo(fifo_bus.store)
    );

    timestamp #(.FREQ(FREQ)) ts (.clk, .reset, .nanoseconds);

    // a zero command word is a soft reset and starts nothing
    always_ff @(posedge clk) begin
        if (!reset) begin
            new_request <= 1'b0;
        end else begin
            new_request <= avs_s0_write && (avs_s0_address == REG_COMMAND)
                           && (avs_s0_writedata != '0);
        end
    end

endmodule : bpfcap_top

//--- verif/bpfcap_sva.sv
`timescale 1ns/1ns
/* bus protocol and controller assertions bound into the capture engine top */
module bpfcap_sva import bpfcap_pkg::*; (
    input logic  clk,
    input logic  reset,
    input logic  avs_m0_read,
    input addr_t avs_m0_address,
    input logic  avs_m0_waitrequest,
    input logic  avs_m1_write,
    input logic  new_request,
    input logic  rd_start,
    input logic  wr_start,
    input logic  done
);
    // a stalled read request must be held unchanged
    a_read_held: assert property (@(posedge clk) disable iff (!reset)
        avs_m0_read && avs_m0_waitrequest |=> avs_m0_read && $stable(avs_m0_address))
        else $error("m0 read dropped or address changed under waitrequest");

    // no master may still drive its bus once the capture is done
    a_done_quiet: assert property (@(posedge clk) disable iff (!reset)
        done |-> !avs_m0_read && !avs_m1_write)
        else $error("bus request still active while capture reports done");

    a_start_pulse: assert property (@(posedge clk) disable iff (!reset)
        (rd_start || wr_start) |-> $past(new_request))
        else $error("master start pulse without a preceding new_request");

endmodule : bpfcap_sva

bind bpfcap_top bpfcap_sva i_sva (
    .clk, .reset, .avs_m0_read, .avs_m0_address, .avs_m0_waitrequest, .avs_m1_write,
    .new_request, .rd_start, .wr_start, .done
);

//--- verif/bpfcap_tb.sv
`timescale 1ns/1ns
/* capture engine testbench with host register driver, read and write memory
   models with random waitrequest and a table of capture cases */
module bpfcap_tb import bpfcap_pkg::*;;
    localparam int NCASES       = 6;
    localparam int DONE_TIMEOUT = 3000; // status polls per capture

    typedef struct packed {
        word_t control;
        addr_t pkt_begin;
        addr_t pkt_end;
        addr_t buf_start;
        word_t buf_size;
        logic  stall;    // random waitrequest and readdatavalid gaps
        logic  exp_wrap;
    } case_t;

    logic      clk;
    logic      reset;
    reg_addr_t avs_s0_address;
    word_t     avs_s0_writedata;
    logic      avs_s0_write;
    logic      avs_s0_read;
    word_t     avs_s0_readdata;
    addr_t     avs_m0_address;
    word_t     avs_m0_readdata;
    logic      avs_m0_read;
    burst_t    avs_m0_burstcount;
    logic      avs_m0_readdatavalid;
    logic      avs_m0_waitrequest;
    addr_t     avs_m1_address;
    word_t     avs_m1_writedata;
    logic      avs_m1_write;
    burst_t    avs_m1_burstcount;
    logic      avs_m1_waitrequest;

    // memory model state
    word_t  rng = 32'h0e6c_9a72;
    logic   stall_en = 1'b0;
    addr_t  rd_addr = '0;
    int     rd_left = 0;
    logic   m0_read_q = 1'b0;
    logic   m0_wait_q = 1'b0;
    addr_t  m0_addr_q = '0;
    burst_t m0_bc_q = '0;
    logic   m1_write_q = 1'b0;
    logic   m1_wait_q = 1'b0;
    addr_t  m1_addr_q = '0;
    burst_t m1_bc_q = '0;
    word_t  m1_data_q = '0;
    int     beat_idx = 0;
    int     beat_count = 0;
    word_t  wr_mem [addr_t]; // captured buffer contents by byte address

    int     err_count = 0;
    int     timeout_count = 0;
    case_t  cases [NCASES];

    bpfcap_top i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic word_t lcg_next(input word_t s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // both models act on the falling edge on what the DUT held at the last rising edge
    always @(negedge clk) begin
        rng = lcg_next(rng);
        if (m0_read_q && !m0_wait_q) begin // burst request accepted
            rd_addr = m0_addr_q;
            rd_left = int'(m0_bc_q);
        end
        if (m1_write_q && !m1_wait_q) begin // one write beat taken
            wr_mem[m1_addr_q + addr_t'(beat_idx * 4)] = m1_data_q;
            beat_count++;
            beat_idx++;
            if (beat_idx == int'(m1_bc_q)) beat_idx = 0;
        end
        if (rd_left != 0 && !(stall_en && rng[29:28] == 2'b00)) begin
            avs_m0_readdatavalid = 1'b1;
            avs_m0_readdata      = rd_addr ^ 32'h5a5a_0000;
            rd_addr              = rd_addr + 32'd4;
            rd_left--;
        end else begin
            avs_m0_readdatavalid = 1'b0;
            avs_m0_readdata      = '0;
        end
        avs_m0_waitrequest = stall_en && (rng[31:30] == 2'b00);
        avs_m1_waitrequest = stall_en && (rng[27:26] == 2'b00);
        m0_read_q  = avs_m0_read;
        m0_addr_q  = avs_m0_address;
        m0_bc_q    = avs_m0_burstcount;
        m0_wait_q  = avs_m0_waitrequest;
        m1_write_q = avs_m1_write;
        m1_addr_q  = avs_m1_address;
        m1_bc_q    = avs_m1_burstcount;
        m1_data_q  = avs_m1_writedata;
        m1_wait_q  = avs_m1_waitrequest;
    end

    task automatic report_mismatch(input string what, input word_t got, input word_t exp);
        err_count++;
        $display("error at %0t: %s is %h, expected %h", $time, what, got, exp);
    endtask

    task automatic host_write(input reg_addr_t a, input word_t d);
        @(negedge clk);
        avs_s0_address   = a;
        avs_s0_writedata = d;
        avs_s0_write     = 1'b1;
        @(negedge clk);
        avs_s0_write = 1'b0;
    endtask

    task automatic host_read(input reg_addr_t a, output word_t d);
        @(negedge clk);
        avs_s0_address = a;
        avs_s0_read    = 1'b1;
        @(negedge clk);
        avs_s0_read = 1'b0;
        d = avs_s0_readdata; // registered on the edge in between
    endtask

    task automatic wait_done(output logic ok);
        word_t st;
        int    n;
        ok = 1'b0;
        repeat (2) @(negedge clk); // start has to reach the FSM first
        for (n = 0; n < DONE_TIMEOUT && !ok; n++) begin
            host_read(REG_STATUS, st);
            ok = st[3];
        end
    endtask

    initial begin
        reg_addr_t reg_list [5];
        word_t     val_list [5];
        case_t     tc;
        word_t     got;
        word_t     expv;
        word_t     prev_stamp;
        addr_t     exp_ptr;
        addr_t     pkt_len;
        addr_t     rec_len;
        addr_t     buf_end;
        addr_t     base;
        addr_t     rec_start;
        addr_t     dst;
        addr_t     a;
        int        beats_before;
        logic      ok;

        avs_s0_address       = '0;
        avs_s0_writedata     = '0;
        avs_s0_write         = 1'b0;
        avs_s0_read          = 1'b0;
        avs_m0_readdata      = '0;
        avs_m0_readdatavalid = 1'b0;
        avs_m0_waitrequest   = 1'b0;
        avs_m1_waitrequest   = 1'b0;
        reset                = 1'b0;
        prev_stamp           = '0;
        exp_ptr              = '0; // write pointer after reset

        //               control  begin    end      start    size     stall wrap
        cases[0] = '{32'd0, 32'h100, 32'h140, 32'h1000, 32'h100, 1'b0, 1'b0};
        cases[1] = '{32'd1, 32'h200, 32'h224, 32'h1000, 32'h100, 1'b0, 1'b0}; // short last burst
        cases[2] = '{32'd1, 32'h300, 32'h380, 32'h1000, 32'h100, 1'b1, 1'b0};
        cases[3] = '{32'd0, 32'h400, 32'h420, 32'h1000, 32'h100, 1'b1, 1'b1}; // runs past end
        cases[4] = '{32'd1, 32'h500, 32'h510, 32'h1000, 32'h100, 1'b1, 1'b0};
        cases[5] = '{32'd0, 32'h600, 32'h6c0, 32'h2000, 32'h400, 1'b1, 1'b0}; // new buffer

        repeat (16) @(negedge clk);
        reset = 1'b1;

        host_read(REG_STATUS, got);
        if (got !== 32'd0) report_mismatch("status after reset", got, 32'd0);
        host_read(REG_LAST_WRITE, got);
        if (got !== 32'd0) report_mismatch("last write after reset", got, 32'd0);

        reg_list = '{REG_CONTROL, REG_PKT_BEGIN, REG_PKT_END, REG_BUF_START, REG_BUF_SIZE};
        val_list = '{32'hc0de_0001, 32'h1234_5670, 32'h2345_6780, 32'h0bad_f00c, 32'h4000};
        for (int r = 0; r < 5; r++) host_write(reg_list[r], val_list[r]);
        for (int r = 0; r < 5; r++) begin
            host_read(reg_list[r], got);
            if (got !== val_list[r]) report_mismatch("register readback", got, val_list[r]);
        end

        // zero command is a soft reset only
        host_write(REG_COMMAND, 32'd0);
        repeat (200) @(negedge clk);
        if (beat_count != 0) begin
            err_count++;
            $display("write beats appeared after a zero command");
        end
        host_read(REG_STATUS, got);
        if (got !== 32'd0) report_mismatch("status after zero command", got, 32'd0);

        for (int i = 0; i < NCASES && timeout_count == 0; i++) begin
            tc       = cases[i];
            stall_en = tc.stall;
            host_write(REG_CONTROL, tc.control);
            host_write(REG_PKT_BEGIN, tc.pkt_begin);
            host_write(REG_PKT_END, tc.pkt_end);
            host_write(REG_BUF_START, tc.buf_start);
            host_write(REG_BUF_SIZE, tc.buf_size);

            pkt_len   = tc.pkt_end - tc.pkt_begin;
            rec_len   = pkt_len + (tc.control[0] ? 32'd8 : 32'd0);
            buf_end   = tc.buf_start + tc.buf_size;
            base      = (exp_ptr >= tc.buf_start && exp_ptr < buf_end) ? exp_ptr : tc.buf_start;
            rec_start = tc.exp_wrap ? tc.buf_start : base;
            wr_mem.delete();
            beats_before = beat_count;

            host_write(REG_COMMAND, 32'd1);
            wait_done(ok);
            if (!ok) begin
                timeout_count++;
                $display("timed out waiting for done in capture case %0d", i);
            end else begin
                host_read(REG_STATUS, got);
                if (got[4] !== tc.exp_wrap) report_mismatch("wrap flag", got[4], tc.exp_wrap);
                host_read(REG_LAST_WRITE, got);
                if (got !== rec_start + rec_len)
                    report_mismatch("last write address", got, rec_start + rec_len);
                if (beat_count - beats_before != int'(rec_len >> 2))
                    report_mismatch("write beat count", beat_count - beats_before, rec_len >> 2);
                dst = rec_start;
                if (tc.control[0]) begin
                    got = wr_mem.exists(dst) ? wr_mem[dst] : 32'hffff_ffff;
                    if (got !== pkt_len) report_mismatch("header length", got, pkt_len);
                    got = wr_mem.exists(dst + 32'd4) ? wr_mem[dst + 32'd4] : 32'd1;
                    if (got % 20 != 0 || got <= prev_stamp) begin
                        err_count++;
                        $display("error at %0t: timestamp %0d after %0d", $time, got, prev_stamp);
                    end
                    prev_stamp = got;
                    dst = dst + 32'd8;
                end
                for (int k = 0; k < int'(pkt_len >> 2); k++) begin
                    a    = dst + addr_t'(k * 4);
                    expv = (tc.pkt_begin + addr_t'(k * 4)) ^ 32'h5a5a_0000;
                    if (!wr_mem.exists(a)) begin
                        err_count++;
                        $display("no write beat reached address %h in case %0d", a, i);
                    end else if (wr_mem[a] !== expv) begin
                        report_mismatch("captured word", wr_mem[a], expv);
                    end
                end
            end
            exp_ptr = rec_start + rec_len;
        end

        $display("checks finished: %0d errors, %0d timeouts", err_count, timeout_count);
        if (err_count == 0 && timeout_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule : bpfcap_tb

//--- verilog.f
design/bpfcap_pkg.sv
design/capture_fifo_if.sv
design/register_bank.sv
design/pkt_ctrl.sv
design/rd_ctrl.sv
design/wr_ctrl.sv
design/capture_fifo.sv
design/timestamp.sv
design/bpfcap_top.sv
verif/bpfcap_sva.sv
verif/bpfcap_tb.sv

//--- run.sh
#!/bin/sh
# build the capture engine testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module bpfcap_tb -f verilog.f -o bpfcap_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/bpfcap_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "All tests passed!" sim.log; then
    exit 0
fi
exit 1
